// ==== rp_analog_top.f ====
logic/rp_bus_pkg.sv
logic/rp_dsp_pkg.sv
logic/sys_bus_decoder.sv
logic/house_keeping.sv
logic/adc_frontend.sv
logic/prop_ctrl.sv
logic/dac_backend.sv
logic/rp_analog_top.sv
verif/rp_analog_asserts.sv
verif/rp_analog_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f rp_analog_top.f \
  --top-module rp_analog_tb -Mdir obj_dir -o rp_analog_sim > build.log 2>&1 &&
./obj_dir/rp_analog_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation passed$" sim.log 2>/dev/null && echo "Run OK" ||
  { echo "Run FAILED, see build.log and sim.log"; exit 1; }

// ==== verif/rp_analog_tb.sv ====
`timescale 1ns/1ps

module rp_analog_tb
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
();

  localparam int          CLK_PERIOD = 40;
  localparam int          KP_SH      = 12;             // Gain fraction bits
  localparam logic [31:0] ID_WORD    = 32'h5250_0001;
  localparam int          N_RAND     = 16;             // Random unity gain entries
  localparam int          TBL_LEN    = N_RAND + 7;
  localparam int          WD_CYCLES  = TBL_LEN * 20 + 200;

  // Byte addresses with the region in the top two bits
  localparam logic [BUS_AW-1:0] A_ID    = 22'h00_0000;
  localparam logic [BUS_AW-1:0] A_LOOP  = 22'h00_0004;
  localparam logic [BUS_AW-1:0] A_LED   = 22'h00_0008;
  localparam logic [BUS_AW-1:0] A_OFS_A = 22'h00_0010;
  localparam logic [BUS_AW-1:0] A_OFS_B = 22'h00_0014;
  localparam logic [BUS_AW-1:0] A_KP_A  = 22'h10_0000;
  localparam logic [BUS_AW-1:0] A_KP_B  = 22'h10_0004;
  localparam logic [BUS_AW-1:0] A_FREE2 = 22'h20_0000;

  // One stimulus entry with its expected DAC codes
  typedef struct packed {
    logic [15:0] adc_a;
    logic [15:0] adc_b;
    logic [13:0] ofs_a;
    logic [13:0] ofs_b;
    logic [13:0] kp_a;
    logic [13:0] kp_b;
    logic        loop;     // Poll for settling instead of fixed latency
    logic [13:0] exp_a;
    logic [13:0] exp_b;
  } vec_t;

  logic                      adc_clk;
  logic                      rst;
  bus_req_t                  bus_req;
  bus_rsp_t                  bus_rsp;
  logic [1:0][ADC_RAW_W-1:0] adc_dat;
  raw_pair_t                 dac_dat;
  logic [7:0]                led;

  vec_t tbl [TBL_LEN];
  int   seed = 32'hd75c_8f3c;
  int   err_cnt = 0;
  int   cur_ofs_a, cur_ofs_b, cur_kp_a, cur_kp_b, cur_loop;  // Last written values

  rp_analog_top #(
    .KP_SHIFT (KP_SH  ),
    .HK_ID    (ID_WORD)
  ) uut (
    .adc_clk   (adc_clk),
    .rst_i     (rst    ),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .adc_dat_i (adc_dat),
    .dac_dat_o (dac_dat),
    .led_o     (led    )
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  initial
  begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the test did not complete", WD_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Negative slope offset binary to signed from the top 14 bits
  function automatic int word_to_smp(input logic [15:0] w);
    logic [13:0] c;
    c = w[15:2];
    return int'($signed({c[13], ~c[12:0]}));
  endfunction

  function automatic int clamp(input int x);
    if (x > int'(SMP_MAX))
      return int'(SMP_MAX);
    if (x < int'(SMP_MIN))
      return int'(SMP_MIN);
    return x;
  endfunction

  function automatic logic [13:0] smp_code(input int s);
    logic [13:0] t;
    t = s[13:0];
    return {t[13], ~t[12:0]};  // Sign kept, rest flipped
  endfunction

  function automatic logic [15:0] smp_word(input int s);
    return {smp_code(s), 2'b00};
  endfunction

  // Gain, shift, clamp, add offset, clamp again
  function automatic logic [13:0] model_dac(input logic [15:0] w, input int ofs, input int kp);
    int fb;
    fb = clamp((word_to_smp(w) * kp) >>> KP_SH);
    return smp_code(clamp(fb + ofs));
  endfunction

  function automatic vec_t make_vec(input logic [15:0] wa, input logic [15:0] wb,
                                    input int oa, input int ob, input int ka, input int kb,
                                    input logic lp);
    vec_t v;
    v.adc_a = wa;
    v.adc_b = wb;
    v.ofs_a = oa[13:0];
    v.ofs_b = ob[13:0];
    v.kp_a  = ka[13:0];
    v.kp_b  = kb[13:0];
    v.loop  = lp;
    v.exp_a = lp ? smp_code(int'(SMP_MAX)) : model_dac(wa, oa, ka);  // Loop ends at the top
    v.exp_b = lp ? smp_code(int'(SMP_MAX)) : model_dac(wb, ob, kb);
    return v;
  endfunction

  task automatic build_table();
    int r;
    tbl[0] = make_vec(smp_word(0), smp_word(0), 1000, -1500, 0, 0, 1'b0);  // Offset only
    r = $random(seed);
    tbl[1] = make_vec(r[15:0], r[31:16], -3000, 2500, 0, 0, 1'b0);         // ADC ignored
    for (int i = 0; i < N_RAND; i++)
    begin
      r = $random(seed);
      tbl[2 + i] = make_vec(r[15:0], r[31:16], 0, 0, 4096, 4096, 1'b0);    // Unity gain
    end
    tbl[N_RAND + 2] = make_vec(smp_word(3000), smp_word(-3000), 7000, -7000, 4096, 4096, 1'b0);
    tbl[N_RAND + 3] = make_vec(smp_word(6000), smp_word(-6000), 0, 0, 8191, 8191, 1'b0);
    tbl[N_RAND + 4] = make_vec(smp_word(-8192), smp_word(5000), 100, -100, -4096, -4096, 1'b0);
    tbl[N_RAND + 5] = make_vec(smp_word(0), smp_word(0), 0, 0, 4096, 4096, 1'b0);  // Loop start
    r = $random(seed);
    tbl[N_RAND + 6] = make_vec(r[15:0], r[31:16], 100, 100, 4096, 4096, 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and bus access
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Single strobe, then wait for ack at falling edges
  task automatic bus_access(input logic [BUS_AW-1:0] addr, input logic wr,
                            input logic [31:0] wdata, output bus_rsp_t rsp);
    int n;
    @(posedge adc_clk);
    bus_req.addr  <= addr;
    bus_req.wdata <= wdata;
    bus_req.wen   <= wr;
    bus_req.ren   <= !wr;
    @(posedge adc_clk);
    bus_req.wen <= 1'b0;
    bus_req.ren <= 1'b0;
    n = 0;
    @(negedge adc_clk);
    while (!bus_rsp.ack && n < 8)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (!bus_rsp.ack)
    begin
      $display("No bus acknowledge for address %h at %0t ns", addr, $time);
      $display("Simulation failed");
      $fatal(1, "bus timeout");
    end
    rsp = bus_rsp;
  endtask

  task automatic bus_write(input logic [BUS_AW-1:0] addr, input logic [31:0] data);
    bus_rsp_t rsp;
    bus_access(addr, 1'b1, data, rsp);
    check_val("write error flag", 32'(rsp.err), 32'd0);
  endtask

  task automatic read_expect(input logic [BUS_AW-1:0] addr, input logic [31:0] exp,
                             input string what);
    bus_rsp_t rsp;
    bus_access(addr, 1'b0, 32'd0, rsp);
    check_val(what, rsp.rdata, exp);
    check_val("read error flag", 32'(rsp.err), 32'd0);
  endtask

  // Skip the write when the register already holds the value
  task automatic update_reg(input logic [BUS_AW-1:0] addr, input int val, inout int cur);
    if (val != cur)
    begin
      bus_write(addr, val);
      cur = val;
    end
  endtask

  task automatic apply_entry(input vec_t v);
    int          n;
    logic [15:0] old_a, old_b;  // Words still in the pipeline
    update_reg(A_OFS_A, $signed(v.ofs_a), cur_ofs_a);
    update_reg(A_OFS_B, $signed(v.ofs_b), cur_ofs_b);
    update_reg(A_KP_A, $signed(v.kp_a), cur_kp_a);
    update_reg(A_KP_B, $signed(v.kp_b), cur_kp_b);
    update_reg(A_LOOP, int'(v.loop), cur_loop);    // Loop enabled last
    old_a = adc_dat[0];
    old_b = adc_dat[1];
    @(posedge adc_clk);
    adc_dat[0] <= v.adc_a;
    adc_dat[1] <= v.adc_b;
    if (v.loop)
    begin
      n = 0;
      @(negedge adc_clk);
      while ((dac_dat.a !== v.exp_a || dac_dat.b !== v.exp_b) && n < 200)
      begin
        @(negedge adc_clk);
        n++;
      end
    end
    else
    begin
      repeat (2) @(posedge adc_clk);
      @(negedge adc_clk);
      // One edge early the old words show with the new registers
      check_val("DAC code a before latency", 32'(dac_dat.a),
                32'(model_dac(old_a, $signed(v.ofs_a), $signed(v.kp_a))));
      check_val("DAC code b before latency", 32'(dac_dat.b),
                32'(model_dac(old_b, $signed(v.ofs_b), $signed(v.kp_b))));
      @(posedge adc_clk);                          // ADC to DAC latency
      @(negedge adc_clk);
    end
    check_val("DAC code a", 32'(dac_dat.a), 32'(v.exp_a));
    check_val("DAC code b", 32'(dac_dat.b), 32'(v.exp_b));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    bus_rsp_t rsp;
    bus_req = '0;
    adc_dat = {2{smp_word(0)}};
    rst     = 1'b1;
    build_table();
    repeat (10) @(posedge adc_clk);
    rst <= 1'b0;
    @(negedge adc_clk);
    // Reset state
    check_val("DAC code a after reset", 32'(dac_dat.a), 32'(smp_code(0)));
    check_val("DAC code b after reset", 32'(dac_dat.b), 32'(smp_code(0)));
    check_val("led_o after reset", 32'(led), 32'd0);
    read_expect(A_ID, ID_WORD, "ID register");
    // Register readback
    bus_write(A_LED, 32'h5A);
    read_expect(A_LED, 32'h5A, "LED register");
    check_val("led_o", 32'(led), 32'h5A);
    bus_write(A_LOOP, 32'd1);
    read_expect(A_LOOP, 32'd1, "loop register");
    bus_write(A_LOOP, 32'd0);
    bus_write(A_OFS_A, -1234);
    read_expect(A_OFS_A, -1234, "offset a register");   // Sign extended
    bus_write(A_OFS_B, 777);
    read_expect(A_OFS_B, 777, "offset b register");
    bus_write(A_KP_A, 4096);
    read_expect(A_KP_A, 4096, "gain a register");
    bus_write(A_KP_B, -2048);
    read_expect(A_KP_B, -2048, "gain b register");
    cur_ofs_a = -1234;
    cur_ofs_b = 777;
    cur_kp_a  = 4096;
    cur_kp_b  = -2048;
    cur_loop  = 0;
    // Unmapped region
    bus_access(A_FREE2, 1'b0, 32'd0, rsp);
    check_val("free region read error flag", 32'(rsp.err), 32'd1);
    check_val("free region read data", rsp.rdata, 32'd0);
    bus_access(A_FREE2 + 22'h4, 1'b1, 32'hDEAD_BEEF, rsp);
    check_val("free region write error flag", 32'(rsp.err), 32'd1);
    for (int i = 0; i < TBL_LEN; i++)
      apply_entry(tbl[i]);
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verif/rp_analog_asserts.sv ====
`timescale 1ns/1ps

module rp_analog_asserts
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
(
  input logic      adc_clk,
  input logic      rst_i,
  input bus_req_t  bus_req_i,
  input bus_rsp_t  bus_rsp_o,
  input raw_pair_t dac_dat_o
);

  logic strobe;

  assign strobe = bus_req_i.wen | bus_req_i.ren;

  //////////////////////////////////////////////////////////////////////
  // Bus handshake
  //////////////////////////////////////////////////////////////////////

  ack_one_cycle: assert property (@(posedge adc_clk) disable iff (rst_i)
    bus_rsp_o.ack |=> !bus_rsp_o.ack)
    else $error("ack high for more than one cycle");

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    strobe |=> bus_rsp_o.ack)
    else $error("no ack one cycle after strobe");

  ack_needs_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    bus_rsp_o.ack |-> $past(strobe))
    else $error("ack without preceding strobe");

  err_with_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    bus_rsp_o.err |-> bus_rsp_o.ack)
    else $error("err without ack");

  single_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(bus_req_i.wen && bus_req_i.ren))
    else $error("wen and ren high together");

  // DAC holds the zero code coming out of reset
  dac_reset_code: assert property (@(posedge adc_clk)
    rst_i |=> (dac_dat_o.a == 14'h1FFF) && (dac_dat_o.b == 14'h1FFF))
    else $error("DAC code not zero after reset");

endmodule

bind rp_analog_top rp_analog_asserts i_asserts (
  .adc_clk   (adc_clk  ),
  .rst_i     (rst_i    ),
  .bus_req_i (bus_req_i),
  .bus_rsp_o (bus_rsp_o),
  .dac_dat_o (dac_dat_o)
);

// ==== logic/rp_analog_top.sv ====
`timescale 1ns/1ps

module rp_analog_top
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
#(
  parameter int                KP_SHIFT = 12,               // Gain fraction bits
  parameter logic [BUS_DW-1:0] HK_ID    = 32'h5250_0001     // ID register value
)(
  input  logic                      adc_clk,
  input  logic                      rst_i,
  // Register bus
  input  bus_req_t                  bus_req_i,
  output bus_rsp_t                  bus_rsp_o,
  // Converters
  input  logic [1:0][ADC_RAW_W-1:0] adc_dat_i,
  output raw_pair_t                 dac_dat_o,
  output logic [7:0]                led_o
);

  bus_req_t  hk_req, pid_req;
  bus_rsp_t  hk_rsp, pid_rsp;
  smp_pair_t adc_smp;       // Into feedback
  smp_pair_t fb_smp;        // Out of feedback
  smp_pair_t dac_smp;       // Loop return
  smp_pair_t offset;
  logic      digital_loop;

  //////////////////////////////////////////////////////////////////////
  // Register bus
  //////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk   (adc_clk  ),
    .rst_i     (rst_i    ),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .hk_req_o  (hk_req   ),
    .hk_rsp_i  (hk_rsp   ),
    .pid_req_o (pid_req  ),
    .pid_rsp_i (pid_rsp  )
  );

  house_keeping #(
    .HK_ID (HK_ID)
  ) i_hk (
    .adc_clk        (adc_clk     ),
    .rst_i          (rst_i       ),
    .bus_req_i      (hk_req      ),
    .bus_rsp_o      (hk_rsp      ),
    .digital_loop_o (digital_loop),
    .led_o          (led_o       ),
    .offset_o       (offset      )
  );

  //////////////////////////////////////////////////////////////////////
  // Data path, ADC to DAC in three registers
  //////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk     ),
    .rst_i          (rst_i       ),
    .adc_dat_i      (adc_dat_i   ),
    .digital_loop_i (digital_loop),
    .dac_smp_i      (dac_smp     ),
    .adc_smp_o      (adc_smp     )
  );

  prop_ctrl #(
    .KP_SHIFT (KP_SHIFT)
  ) i_pid (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i  ),
    .bus_req_i (pid_req),
    .bus_rsp_o (pid_rsp),
    .adc_smp_i (adc_smp),
    .fb_smp_o  (fb_smp )
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk  ),
    .rst_i     (rst_i    ),
    .fb_smp_i  (fb_smp   ),
    .offset_i  (offset   ),
    .dac_smp_o (dac_smp  ),
    .dac_dat_o (dac_dat_o)
  );

endmodule

// ==== logic/dac_backend.sv ====
`timescale 1ns/1ps

module dac_backend
  import rp_dsp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_i,
  input  smp_pair_t fb_smp_i,   // From feedback stage
  input  smp_pair_t offset_i,   // DC level per channel
  output smp_pair_t dac_smp_o,  // Saturated value, back to the loop
  output raw_pair_t dac_dat_o   // Converter codes
);

  logic signed [SMP_W:0] sum_a, sum_b;  // One guard bit
  smp_pair_t             sat;

  //////////////////////////////////////////////////////////////////////
  // Sum and clamp
  //////////////////////////////////////////////////////////////////////

  assign sum_a = fb_smp_i.a + offset_i.a;
  assign sum_b = fb_smp_i.b + offset_i.b;

  assign sat.a = sat_smp(sum_a);  // Sign extended into the wide clamp
  assign sat.b = sat_smp(sum_b);

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  // Loop copy registered alongside the code
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_smp_o   <= '0;
      dac_dat_o.a <= CODE_FLIP;    // Code of zero
      dac_dat_o.b <= CODE_FLIP;
    end
    else
    begin
      dac_smp_o   <= sat;
      dac_dat_o.a <= smp_to_code(sat.a);  // Back to negative slope
      dac_dat_o.b <= smp_to_code(sat.b);
    end
  end

endmodule

// ==== logic/prop_ctrl.sv ====
`timescale 1ns/1ps

module prop_ctrl
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
#(
  parameter int KP_SHIFT = 12  // Fraction bits of the gain
)(
  input  logic      adc_clk,
  input  logic      rst_i,
  input  bus_req_t  bus_req_i,
  output bus_rsp_t  bus_rsp_o,
  input  smp_pair_t adc_smp_i,
  output smp_pair_t fb_smp_o   // Registered feedback
);

  localparam logic [BUS_OW-1:0] OFS_KP_A = BUS_OW'(32'h00);
  localparam logic [BUS_OW-1:0] OFS_KP_B = BUS_OW'(32'h04);

  smp_t                     kp_a, kp_b;      // Signed gains
  logic                     ack_q;
  logic [BUS_DW-1:0]        rdata_q;
  logic signed [WIDE_W-1:0] prod_a, prod_b;  // Full products
  logic signed [WIDE_W-1:0] shr_a, shr_b;    // Back to sample scale

  //////////////////////////////////////////////////////////////////////
  // Gain registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      kp_a  <= '0;
      kp_b  <= '0;
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= bus_req_i.wen | bus_req_i.ren;
      if (bus_req_i.wen)
      begin
        case (bus_req_i.addr[BUS_OW-1:0])
          OFS_KP_A: kp_a <= smp_t'(bus_req_i.wdata[SMP_W-1:0]);
          OFS_KP_B: kp_b <= smp_t'(bus_req_i.wdata[SMP_W-1:0]);
          default:  ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
    begin
      case (bus_req_i.addr[BUS_OW-1:0])
        OFS_KP_A: rdata_q <= BUS_DW'(kp_a);   // Sign extended readback
        OFS_KP_B: rdata_q <= BUS_DW'(kp_b);
        default:  rdata_q <= '0;
      endcase
    end
  end

  assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q, err: 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Proportional stage
  //////////////////////////////////////////////////////////////////////

  assign prod_a = adc_smp_i.a * kp_a;
  assign prod_b = adc_smp_i.b * kp_b;
  assign shr_a  = prod_a >>> KP_SHIFT;  // Arithmetic, keeps sign
  assign shr_b  = prod_b >>> KP_SHIFT;

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      fb_smp_o <= '0;
    else
    begin
      fb_smp_o.a <= sat_smp(shr_a);   // Clamp, then register
      fb_smp_o.b <= sat_smp(shr_b);
    end
  end

endmodule

// ==== logic/adc_frontend.sv ====
`timescale 1ns/1ps

module adc_frontend
  import rp_dsp_pkg::*;
(
  input  logic                      adc_clk,
  input  logic                      rst_i,
  input  logic [1:0][ADC_RAW_W-1:0] adc_dat_i,       // [0] is channel a
  input  logic                      digital_loop_i,
  input  smp_pair_t                 dac_smp_i,       // Saturated DAC value
  output smp_pair_t                 adc_smp_o
);

  raw_pair_t raw_q;   // Top bits of the ADC words
  smp_pair_t conv;

  //////////////////////////////////////////////////////////////////////
  // Input register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      raw_q.a <= CODE_FLIP;  // Code of zero
      raw_q.b <= CODE_FLIP;
    end
    else
    begin
      // Two LSBs dropped
      raw_q.a <= adc_dat_i[0][ADC_RAW_W-1 -: SMP_W];
      raw_q.b <= adc_dat_i[1][ADC_RAW_W-1 -: SMP_W];
    end
  end

  // Offset binary, negative slope, to two's complement
  assign conv.a = code_to_smp(raw_q.a);
  assign conv.b = code_to_smp(raw_q.b);

  // Loop mode swaps in the DAC value
  assign adc_smp_o = digital_loop_i ? dac_smp_i : conv;

endmodule

// ==== logic/house_keeping.sv ====
`timescale 1ns/1ps

module house_keeping
  import rp_bus_pkg::*;
  import rp_dsp_pkg::*;
#(
  parameter logic [BUS_DW-1:0] HK_ID = 32'h5250_0001  // Board identification
)(
  input  logic       adc_clk,
  input  logic       rst_i,
  input  bus_req_t   bus_req_i,
  output bus_rsp_t   bus_rsp_o,
  output logic       digital_loop_o,  // DAC back into ADC path
  output logic [7:0] led_o,
  output smp_pair_t  offset_o         // DC added ahead of the DAC
);

  // Register offsets in bytes
  localparam logic [BUS_OW-1:0] OFS_ID    = BUS_OW'(32'h00);
  localparam logic [BUS_OW-1:0] OFS_LOOP  = BUS_OW'(32'h04);
  localparam logic [BUS_OW-1:0] OFS_LED   = BUS_OW'(32'h08);
  localparam logic [BUS_OW-1:0] OFS_OFS_A = BUS_OW'(32'h10);
  localparam logic [BUS_OW-1:0] OFS_OFS_B = BUS_OW'(32'h14);

  logic [BUS_OW-1:0] ofs;
  logic              ack_q;
  logic [BUS_DW-1:0] rdata_q;

  assign ofs = bus_req_i.addr[BUS_OW-1:0];

  //////////////////////////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_q          <= 1'b0;
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      offset_o       <= '0;
    end
    else
    begin
      ack_q <= bus_req_i.wen | bus_req_i.ren;  // Writes ack too
      if (bus_req_i.wen)
      begin
        case (ofs)
          OFS_LOOP:  digital_loop_o <= bus_req_i.wdata[0];
          OFS_LED:   led_o          <= bus_req_i.wdata[7:0];
          OFS_OFS_A: offset_o.a     <= smp_t'(bus_req_i.wdata[SMP_W-1:0]);
          OFS_OFS_B: offset_o.b     <= smp_t'(bus_req_i.wdata[SMP_W-1:0]);
          default:   ;                // ID and holes ignore writes
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
    begin
      case (ofs)
        OFS_ID:    rdata_q <= HK_ID;
        OFS_LOOP:  rdata_q <= BUS_DW'(digital_loop_o);
        OFS_LED:   rdata_q <= BUS_DW'(led_o);
        OFS_OFS_A: rdata_q <= BUS_DW'(offset_o.a);  // Sign extended
        OFS_OFS_B: rdata_q <= BUS_DW'(offset_o.b);
        default:   rdata_q <= '0;
      endcase
    end
  end

  assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q, err: 1'b0};

endmodule

// ==== logic/sys_bus_decoder.sv ====
`timescale 1ns/1ps

module sys_bus_decoder
  import rp_bus_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_i,
  input  bus_req_t bus_req_i,   // From outside
  output bus_rsp_t bus_rsp_o,
  output bus_req_t hk_req_o,    // Housekeeping region
  input  bus_rsp_t hk_rsp_i,
  output bus_req_t pid_req_o,   // Feedback region
  input  bus_rsp_t pid_rsp_i
);

  bus_region_e       region;     // Region of the current request
  bus_region_e       region_q;   // Region of the last strobe
  logic [BUS_OW-1:0] ofs;
  logic              strobe;
  logic              unmapped;
  logic              err_q;      // Error ack for free regions

  assign region   = bus_region_e'(bus_req_i.addr[BUS_AW-1 -: BUS_RW]);
  assign ofs      = bus_req_i.addr[BUS_OW-1:0];
  assign strobe   = bus_req_i.wen | bus_req_i.ren;
  assign unmapped = (region == REG_FREE2) || (region == REG_FREE3);

  //////////////////////////////////////////////////////////////////////
  // Request fan-out
  //////////////////////////////////////////////////////////////////////

  // Blocks see the offset only, strobes gated by region
  always_comb
  begin
    hk_req_o.addr   = {{BUS_RW{1'b0}}, ofs};
    hk_req_o.wdata  = bus_req_i.wdata;
    hk_req_o.wen    = bus_req_i.wen & (region == REG_HK);
    hk_req_o.ren    = bus_req_i.ren & (region == REG_HK);
    pid_req_o.addr  = {{BUS_RW{1'b0}}, ofs};
    pid_req_o.wdata = bus_req_i.wdata;
    pid_req_o.wen   = bus_req_i.wen & (region == REG_PID);
    pid_req_o.ren   = bus_req_i.ren & (region == REG_PID);
  end

  //////////////////////////////////////////////////////////////////////
  // Response select
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      region_q <= REG_HK;
      err_q    <= 1'b0;
    end
    else
    begin
      err_q <= strobe & unmapped;     // Lines up with block acks
      if (strobe)
        region_q <= region;           // Hold until next strobe
    end
  end

  // Passed through, no extra cycle
  always_comb
  begin
    case (region_q)
      REG_HK:  bus_rsp_o = hk_rsp_i;
      REG_PID: bus_rsp_o = pid_rsp_i;
      default: bus_rsp_o = '{rdata: '0, ack: err_q, err: err_q};  // Free regions
    endcase
  end

endmodule

// ==== logic/rp_dsp_pkg.sv ====
package rp_dsp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sample formats
  //////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;         // ADC word, two LSBs unused
  localparam int SMP_W     = 14;         // Converter resolution
  localparam int WIDE_W    = 2 * SMP_W;  // Product width, also holds any sum

  typedef logic signed [SMP_W-1:0] smp_t;  // Two's complement sample

  typedef struct packed {
    smp_t a;
    smp_t b;
  } smp_pair_t;

  // Converter side codes, negative slope offset binary
  typedef struct packed {
    logic [SMP_W-1:0] a;
    logic [SMP_W-1:0] b;
  } raw_pair_t;

  localparam smp_t SMP_MAX = smp_t'(8191);
  localparam smp_t SMP_MIN = smp_t'(-8192);

  // Sign bit kept, magnitude bits flipped
  localparam logic [SMP_W-1:0] CODE_FLIP = {1'b0, {(SMP_W-1){1'b1}}};

  // Converter code to sample
  function automatic smp_t code_to_smp(input logic [SMP_W-1:0] code);
    return smp_t'(code ^ CODE_FLIP);
  endfunction

  // Sample to converter code, same flip both ways
  function automatic logic [SMP_W-1:0] smp_to_code(input smp_t smp);
    return $unsigned(smp) ^ CODE_FLIP;
  endfunction

  // Clamp a wide signed value to sample range
  function automatic smp_t sat_smp(input logic signed [WIDE_W-1:0] x);
    if (x > SMP_MAX)
      return SMP_MAX;
    else if (x < SMP_MIN)
      return SMP_MIN;
    return smp_t'(x);
  endfunction

endpackage

// ==== logic/rp_bus_pkg.sv ====
package rp_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register bus geometry
  //////////////////////////////////////////////////////////////////////

  localparam int BUS_OW = 20;               // Byte offset bits inside a region
  localparam int BUS_RW = 2;                // Region select bits on top
  localparam int BUS_AW = BUS_OW + BUS_RW;  // Full byte address
  localparam int BUS_DW = 32;               // Data word

  // Address regions, top bits of addr
  typedef enum logic [BUS_RW-1:0] {
    REG_HK    = 2'd0,  // Housekeeping
    REG_PID   = 2'd1,  // Proportional feedback
    REG_FREE2 = 2'd2,  // Unmapped
    REG_FREE3 = 2'd3   // Unmapped
  } bus_region_e;

  // Request, strobes last one cycle
  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic              wen;   // Write strobe
    logic              ren;   // Read strobe
  } bus_req_t;

  // Response, ack one cycle after strobe
  typedef struct packed {
    logic [BUS_DW-1:0] rdata;  // Valid with ack
    logic              ack;
    logic              err;    // Only together with ack
  } bus_rsp_t;

endpackage
